//--- source/cart_load_pkg.sv
package cart_load_pkg;

	// loader stream widths
	localparam int LOAD_ADDR_W = 25;
	localparam int LOAD_DATA_W = 16;

	// 128 KiB of byte-wide work ram
	localparam int WRAM_ADDR_W = 17;

	// rom and save-ram address masks
	localparam int MASK_W = 24;

	// size code used when the header carries none
	localparam logic [3:0] DEFAULT_ROM_SIZE = 4'd12;

	// size word of each forced map, behind the 512-byte copier header
	localparam logic [LOAD_ADDR_W-1:0] HDR_LOROM_SIZE_ADDR = 25'h7FD6 + 25'h200;
	localparam logic [LOAD_ADDR_W-1:0] HDR_HIROM_SIZE_ADDR = 25'hFFD6 + 25'h200;
	localparam logic [LOAD_ADDR_W-1:0] HDR_EXHIROM_SIZE_ADDR = 25'h40FFD6 + 25'h200;

	// cycles per fill-address step, and the divider that counts them
	localparam int CLEAR_STEP_DIV = 4;
	localparam int CLEAR_DIV_W = $clog2(CLEAR_STEP_DIV);

	typedef enum logic [2:0] {
		map_auto = 3'd0,
		map_lorom_a = 3'd1,
		map_lorom = 3'd2,
		map_hirom = 3'd3,
		map_exhirom = 3'd4
	} map_override_t;

	typedef enum logic [1:0] {
		std_header = 2'd0,
		std_ntsc = 2'd1,
		std_pal = 2'd2
	} video_std_t;

	typedef enum logic [1:0] {
		fill_checker = 2'd0,
		fill_stripe = 2'd1,
		fill_55 = 2'd2,
		fill_ff = 2'd3
	} fill_pattern_t;

endpackage

//--- source/load_stream_if.sv
`timescale 1ns/10ps

interface load_stream_if;
	import cart_load_pkg::*;

	// high for the whole load
	logic download;
	// one strobe per word, no back-pressure
	logic wr;
	// even byte address
	logic [LOAD_ADDR_W-1:0] addr;
	logic [LOAD_DATA_W-1:0] dout;

	// loader side
	modport source (output download, wr, addr, dout);

	// header detect and clear engine
	modport sink (input download, wr, addr, dout);

endinterface

//--- source/cart_header_detect.sv
`timescale 1ns/10ps

module cart_header_detect (
	input logic clk_sys,
	input logic reset,
	load_stream_if.sink load,
	input cart_load_pkg::map_override_t lhrom_type,
	input cart_load_pkg::video_std_t video_std,
	output logic [7:0] rom_type,
	output logic [cart_load_pkg::MASK_W-1:0] rom_mask,
	output logic [cart_load_pkg::MASK_W-1:0] ram_mask,
	output logic pal
);
	import cart_load_pkg::*;

	logic accept;
	logic [3:0] rom_size;
	logic [3:0] ram_size;
	logic region;
	logic [3:0] rom_size_next;
	logic [3:0] ram_size_next;
	logic [7:0] rom_type_next;
	logic region_next;
	logic has_size_word;
	logic [LOAD_ADDR_W-1:0] size_addr;

	// size code n covers 1 KiB << n
	function automatic logic [MASK_W-1:0] size_to_mask(input logic [3:0] code);
		size_to_mask = (MASK_W'(1024) << code) - MASK_W'(1);
	endfunction

	assign accept = load.download & load.wr;

	// size word position of the forced map
	always_comb begin
		has_size_word = 1'b1;
		size_addr = HDR_LOROM_SIZE_ADDR;
		case (lhrom_type)
			map_lorom: size_addr = HDR_LOROM_SIZE_ADDR;
			map_hirom: size_addr = HDR_HIROM_SIZE_ADDR;
			map_exhirom: size_addr = HDR_EXHIROM_SIZE_ADDR;
			default: has_size_word = 1'b0;
		endcase
	end

	// next header state for the word on the bus
	always_comb begin
		rom_size_next = rom_size;
		ram_size_next = ram_size;
		rom_type_next = rom_type;
		region_next = region;
		if (load.addr == '0) begin
			rom_size_next = DEFAULT_ROM_SIZE;
			ram_size_next = 4'd0;
			// auto map trusts the packed size byte when present
			if (lhrom_type == map_auto && load.dout[7:0] != 8'd0) begin
				{ram_size_next, rom_size_next} = load.dout[7:0];
			end
			case (lhrom_type)
				map_lorom_a, map_lorom: rom_type_next = 8'd0;
				map_hirom: rom_type_next = 8'd1;
				map_exhirom: rom_type_next = 8'd2;
				default: rom_type_next = load.dout[15:8];
			endcase
		end
		if (load.addr == LOAD_ADDR_W'(2)) begin
			region_next = load.dout[8];
		end
		// forced map reads sizes straight from the internal header
		if (has_size_word && load.addr == size_addr) begin
			rom_size_next = load.dout[11:8];
		end
		if (has_size_word && load.addr == size_addr + LOAD_ADDR_W'(2)) begin
			ram_size_next = load.dout[3:0];
		end
	end

	// masks registered alongside the codes, valid the cycle after the word
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_size <= 4'd0;
			ram_size <= 4'd0;
			region <= 1'b0;
			rom_type <= 8'd0;
			rom_mask <= '0;
			ram_mask <= '0;
			pal <= 1'b0;
		end else begin
			if (accept) begin
				rom_size <= rom_size_next;
				ram_size <= ram_size_next;
				region <= region_next;
				rom_type <= rom_type_next;
				rom_mask <= size_to_mask(rom_size_next);
				ram_mask <= (ram_size_next != 4'd0) ? size_to_mask(ram_size_next) : '0;
			end
			// video standard frozen while loading
			if (!load.download) begin
				case (video_std)
					std_header: pal <= region;
					std_pal: pal <= 1'b1;
					default: pal <= 1'b0;
				endcase
			end
		end
	end

	// a map change mid-load would mix two header layouts
	assert property (@(posedge clk_sys) disable iff (!reset)
		load.download && $past(load.download) |-> $stable(lhrom_type));

endmodule

//--- source/ram_clear_engine.sv
`timescale 1ns/10ps

module ram_clear_engine (
	input logic clk_sys,
	input logic reset,
	load_stream_if.sink load,
	input cart_load_pkg::fill_pattern_t fill_pattern,
	output logic clearing,
	output logic [cart_load_pkg::WRAM_ADDR_W-1:0] fill_addr,
	output logic [7:0] fill_data
);
	import cart_load_pkg::*;

	logic download_q;
	logic download_start;
	logic [CLEAR_DIV_W-1:0] clear_div;

	// rising edge of download
	assign download_start = load.download & ~download_q;

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			download_q <= 1'b0;
			clear_div <= '0;
			clearing <= 1'b0;
			fill_addr <= '0;
		end else begin
			download_q <= load.download;
			// free-running step divider
			if (clear_div == CLEAR_DIV_W'(CLEAR_STEP_DIV - 1)) begin
				clear_div <= '0;
			end else begin
				clear_div <= clear_div + 1'b1;
			end
			if (download_start) begin
				clearing <= 1'b1;
			end else if (&fill_addr) begin
				clearing <= 1'b0;
			end
			// last address written, park back at zero
			if (!clearing || (&fill_addr)) begin
				fill_addr <= '0;
			end else if (clear_div == '0) begin
				fill_addr <= fill_addr + 1'b1;
			end
		end
	end

	// power-on pattern from the address bits
	always_comb begin
		fill_data = 8'h00;
		case (fill_pattern)
			fill_checker: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			fill_stripe: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			fill_55: fill_data = 8'h55;
			fill_ff: fill_data = 8'hFF;
		endcase
	end

	// a pattern change mid-clear would leave two fills in the ram
	assert property (@(posedge clk_sys) disable iff (!reset)
		clearing |-> $stable(fill_pattern));

endmodule

//--- source/work_ram.sv
`timescale 1ns/10ps

module work_ram (
	input logic clk_sys,
	input logic [cart_load_pkg::WRAM_ADDR_W-1:0] wram_addr,
	input logic [7:0] wram_d,
	input logic wram_we,
	output logic [7:0] wram_q,
	input logic [cart_load_pkg::WRAM_ADDR_W-1:0] fill_addr,
	input logic [7:0] fill_data,
	input logic clearing
);
	import cart_load_pkg::*;

	logic [7:0] mem [0:(2**WRAM_ADDR_W)-1];

	// port a belongs to the core, port b to the fill
	always_ff @(posedge clk_sys) begin
		if (wram_we) begin
			mem[wram_addr] <= wram_d;
		end
		if (clearing) begin
			mem[fill_addr] <= fill_data;
		end
		// read returns old data on a same-cycle write
		wram_q <= mem[wram_addr];
	end

	// core is held in reset for the whole clear
	assert property (@(posedge clk_sys) clearing |-> !wram_we);

endmodule

//--- source/reset_sequencer.sv
`timescale 1ns/10ps

module reset_sequencer (
	input logic clk_sys,
	input logic reset,
	input logic download,
	input logic clearing,
	output logic core_reset_n
);

	logic [1:0] div;
	logic busy;

	// anything that owns the memories keeps the core down
	assign busy = download | clearing;

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			div <= 2'd0;
			core_reset_n <= 1'b0;
		end else begin
			div <= div + 1'b1;
			// assert at once, release only on phase 2
			if (busy) begin
				core_reset_n <= 1'b0;
			end else if (div == 2'd2) begin
				core_reset_n <= 1'b1;
			end
		end
	end

	// core never runs against a half-cleared ram
	assert property (@(posedge clk_sys) disable iff (!reset)
		clearing |-> !core_reset_n);

endmodule

//--- source/cart_load_top.sv
`timescale 1ns/10ps

module cart_load_top (
	input logic clk_sys,
	input logic reset,
	input logic ioctl_download,
	input logic ioctl_wr,
	input logic [cart_load_pkg::LOAD_ADDR_W-1:0] ioctl_addr,
	input logic [cart_load_pkg::LOAD_DATA_W-1:0] ioctl_dout,
	input cart_load_pkg::map_override_t lhrom_type,
	input cart_load_pkg::video_std_t video_std,
	input cart_load_pkg::fill_pattern_t fill_pattern,
	input logic [cart_load_pkg::WRAM_ADDR_W-1:0] wram_addr,
	input logic [7:0] wram_d,
	input logic wram_we,
	output logic [7:0] wram_q,
	output logic [7:0] rom_type,
	output logic [cart_load_pkg::MASK_W-1:0] rom_mask,
	output logic [cart_load_pkg::MASK_W-1:0] ram_mask,
	output logic pal,
	output logic clearing,
	output logic core_reset_n
);

	load_stream_if load_bus ();

	logic [cart_load_pkg::WRAM_ADDR_W-1:0] fill_addr;
	logic [7:0] fill_data;

	// loader pins onto the shared stream
	assign load_bus.download = ioctl_download;
	assign load_bus.wr = ioctl_wr;
	assign load_bus.addr = ioctl_addr;
	assign load_bus.dout = ioctl_dout;

	cart_header_detect header_detect_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.load(load_bus.sink),
		.lhrom_type(lhrom_type),
		.video_std(video_std),
		.rom_type(rom_type),
		.rom_mask(rom_mask),
		.ram_mask(ram_mask),
		.pal(pal)
	);

	ram_clear_engine clear_engine_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.load(load_bus.sink),
		.fill_pattern(fill_pattern),
		.clearing(clearing),
		.fill_addr(fill_addr),
		.fill_data(fill_data)
	);

	// fill port driven only by the clear engine
	work_ram work_ram_inst (
		.clk_sys(clk_sys),
		.wram_addr(wram_addr),
		.wram_d(wram_d),
		.wram_we(wram_we),
		.wram_q(wram_q),
		.fill_addr(fill_addr),
		.fill_data(fill_data),
		.clearing(clearing)
	);

	reset_sequencer reset_sequencer_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.download(ioctl_download),
		.clearing(clearing),
		.core_reset_n(core_reset_n)
	);

endmodule

//--- test/cart_load_checks.svh
`ifndef CART_LOAD_CHECKS_SVH
`define CART_LOAD_CHECKS_SVH

	// first error ends the run
	task automatic stop_run();
		checks_failed++;
		$display("** FAIL **");
		$fatal(1, "simulation stopped at first error");
	endtask

	// wrong value, with time
	task automatic fail_value(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		stop_run();
	endtask

	// timeouts, file trouble
	task automatic fail_plain(input string msg);
		$display("%s", msg);
		stop_run();
	endtask

	// single control level such as clearing or core_reset_n
	task automatic check_level(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			fail_value($sformatf("%s: got %b, expected %b", what, got, exp));
		end
	endtask

	// cart info straight off the top-level outputs
	task automatic check_cart(input logic [7:0] exp_type, input logic [MASK_W-1:0] exp_rom,
			input logic [MASK_W-1:0] exp_ram, input logic exp_pal);
		if (rom_type !== exp_type) begin
			fail_value($sformatf("rom_type: got %02h, expected %02h", rom_type, exp_type));
		end
		if (rom_mask !== exp_rom) begin
			fail_value($sformatf("rom_mask: got %06h, expected %06h", rom_mask, exp_rom));
		end
		if (ram_mask !== exp_ram) begin
			fail_value($sformatf("ram_mask: got %06h, expected %06h", ram_mask, exp_ram));
		end
		if (pal !== exp_pal) begin
			fail_value($sformatf("pal: got %b, expected %b", pal, exp_pal));
		end
	endtask

	// work ram byte, pattern shown for context
	task automatic check_byte(input logic [WRAM_ADDR_W-1:0] addr, input logic [7:0] got,
			input logic [7:0] exp, input fill_pattern_t pat);
		if (got !== exp) begin
			fail_value($sformatf("wram %05h (%s): got %02h, expected %02h",
				addr, pat.name(), got, exp));
		end
	endtask

`endif

//--- test/cart_load_tb.sv
`timescale 1ns/10ps

module cart_load_tb;
	import cart_load_pkg::*;

	localparam int CLEAR_TIMEOUT = 600000;
	localparam int RELEASE_LIMIT = 4;

	logic clk_sys;
	logic reset;
	logic ioctl_download;
	logic ioctl_wr;
	logic [LOAD_ADDR_W-1:0] ioctl_addr;
	logic [LOAD_DATA_W-1:0] ioctl_dout;
	map_override_t lhrom_type;
	video_std_t video_std;
	fill_pattern_t fill_pattern;
	logic [WRAM_ADDR_W-1:0] wram_addr;
	logic [7:0] wram_d;
	logic wram_we;
	logic [7:0] wram_q;
	logic [7:0] rom_type;
	logic [MASK_W-1:0] rom_mask;
	logic [MASK_W-1:0] ram_mask;
	logic pal;
	logic clearing;
	logic core_reset_n;
	int checks_failed;
	logic loading;

	`include "cart_load_checks.svh"

	cart_load_top cart_load_top_inst (.*);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#10 clk_sys = ~clk_sys;
		end
	end

	// one loader word, wr high for a single cycle
	task automatic put_word(input logic [LOAD_ADDR_W-1:0] addr,
			input logic [LOAD_DATA_W-1:0] data);
		@(negedge clk_sys);
		ioctl_wr = 1'b1;
		ioctl_addr = addr;
		ioctl_dout = data;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		check_level("core_reset_n during download", core_reset_n, 1'b0);
	endtask

	// fillers land in 0x1000..0x1ffe, clear of every header field
	task automatic send_header_word(input logic [LOAD_ADDR_W-1:0] addr,
			input logic [LOAD_DATA_W-1:0] data);
		int fillers;
		fillers = $urandom % 3;
		repeat (fillers) begin
			put_word(LOAD_ADDR_W'(32'h1000 | ($urandom & 32'h0FFE)), LOAD_DATA_W'($urandom));
		end
		put_word(addr, data);
	endtask

	task automatic wait_release(input string when_text);
		int cycles;
		cycles = 0;
		while (!core_reset_n) begin
			if (cycles == RELEASE_LIMIT) begin
				fail_plain({"core reset not released within 4 cycles ", when_text});
			end
			@(negedge clk_sys);
			cycles++;
		end
	endtask

	// settings one cycle ahead, then download and the clear behind it
	task automatic start_download(input map_override_t map, input video_std_t std,
			input fill_pattern_t pat);
		int cycles;
		@(negedge clk_sys);
		lhrom_type = map;
		video_std = std;
		fill_pattern = pat;
		@(negedge clk_sys);
		ioctl_download = 1'b1;
		loading = 1'b1;
		cycles = 0;
		while (!clearing) begin
			if (cycles == 2) begin
				fail_plain("clearing did not rise after the download started");
			end
			@(negedge clk_sys);
			cycles++;
		end
	endtask

	// core stays in reset for the whole clear
	task automatic finish_download();
		int cycles;
		@(negedge clk_sys);
		ioctl_download = 1'b0;
		loading = 1'b0;
		cycles = 0;
		while (clearing) begin
			check_level("core_reset_n during clear", core_reset_n, 1'b0);
			if (cycles == CLEAR_TIMEOUT) begin
				fail_plain("timeout: clearing still high after 600000 cycles");
			end
			@(negedge clk_sys);
			cycles++;
		end
		wait_release("after the clear");
	endtask

	// registered read, data one cycle after the address
	task automatic read_wram(input logic [WRAM_ADDR_W-1:0] addr, output logic [7:0] data);
		@(negedge clk_sys);
		wram_addr = addr;
		@(negedge clk_sys);
		data = wram_q;
	endtask

	initial begin
		int fd;
		int code;
		int seed;
		logic [8*8-1:0] kind;
		logic [8*160-1:0] line;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [31:0] f4;
		logic [7:0] got;
		checks_failed = 0;
		loading = 1'b0;
		reset = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		lhrom_type = map_auto;
		video_std = std_header;
		fill_pattern = fill_checker;
		wram_addr = '0;
		wram_d = 8'h00;
		wram_we = 1'b0;
		seed = $urandom(32'hbca2);
		repeat (16) @(negedge clk_sys);
		check_level("clearing in reset", clearing, 1'b0);
		check_level("core_reset_n in reset", core_reset_n, 1'b0);
		reset = 1'b1;
		wait_release("after reset");

		fd = $fopen("test/cart_load_stim.txt", "r");
		if (fd == 0) begin
			fail_plain("cannot open test/cart_load_stim.txt");
		end
		code = $fscanf(fd, "%s", kind);
		while (code == 1) begin
			if (kind == "#") begin
				code = $fgets(line, fd);
			end else if (kind == "set") begin
				code = $fscanf(fd, "%h %h %h", f1, f2, f3);
				if (code != 3) fail_plain("malformed set record in stim file");
				if (loading) finish_download();
				start_download(map_override_t'(f1[2:0]), video_std_t'(f2[1:0]),
					fill_pattern_t'(f3[1:0]));
			end else if (kind == "word") begin
				code = $fscanf(fd, "%h %h", f1, f2);
				if (code != 2 || !loading) fail_plain("word record outside a download");
				send_header_word(f1[LOAD_ADDR_W-1:0], f2[LOAD_DATA_W-1:0]);
			end else if (kind == "cart") begin
				code = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
				if (code != 4) fail_plain("malformed cart record in stim file");
				if (loading) finish_download();
				check_cart(f1[7:0], f2[MASK_W-1:0], f3[MASK_W-1:0], f4[0]);
			end else if (kind == "fill") begin
				code = $fscanf(fd, "%h %h", f1, f2);
				if (code != 2) fail_plain("malformed fill record in stim file");
				if (loading) finish_download();
				read_wram(f1[WRAM_ADDR_W-1:0], got);
				check_byte(f1[WRAM_ADDR_W-1:0], got, f2[7:0], fill_pattern);
			end else begin
				fail_plain($sformatf("unknown stim record %0s", kind));
			end
			code = $fscanf(fd, "%s", kind);
		end
		$fclose(fd);
		if (loading) finish_download();

		// core owns port a once released
		@(negedge clk_sys);
		wram_addr = 17'h0F0F0;
		wram_d = 8'($urandom);
		wram_we = 1'b1;
		@(negedge clk_sys);
		wram_we = 1'b0;
		read_wram(17'h0F0F0, got);
		check_byte(17'h0F0F0, got, wram_d, fill_pattern);

		if (checks_failed == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- test/cart_load_stim.txt
# set: map std pattern | word: addr data | cart: rom_type rom_mask ram_mask pal
# fill: wram addr, expected byte | all fields hex
# auto map, size byte 3a, region bit set, checker fill
set 0 0 0
word 0000000 213A
word 0000002 0100
cart 21 0FFFFF 001FFF 1
fill 00000 99
fill 00004 66
fill 00100 66
fill 00104 99
fill 0ABCD 99
fill 1FFFF 99
# hirom, size words behind the copier header, ntsc forced, stripe fill
set 3 1 1
word 0000000 3321
word 0000002 0100
word 00101D6 0B00
word 00101D8 0005
cart 01 1FFFFF 007FFF 0
fill 00000 00
fill 00001 FF
fill 00200 FF
fill 00201 00
fill 0ABCC FF
fill 1FFFF 00
# lorom, zero size byte and no size word, pal forced, constant fill
set 2 2 2
word 0000000 5A00
cart 00 3FFFFF 000000 1
fill 00000 55
fill 12345 55
fill 1FFFF 55

//--- sim.f
+incdir+test
source/cart_load_pkg.sv
source/load_stream_if.sv
source/cart_header_detect.sv
source/ram_clear_engine.sv
source/work_ram.sv
source/reset_sequencer.sv
source/cart_load_top.sv
test/cart_load_tb.sv
